// ==== rtl/imager_settings.svh ====
// Imager controller settings
`ifndef IMAGER_SETTINGS_SVH
`define IMAGER_SETTINGS_SVH

// Pixel array size
`define ROW_RESOLUTION 112
`define COL_RESOLUTION 112
`define PIXEL_IDX_BITS 7

// On-chip register map
`define REG_PTR_BITS   3
`define REG_VALUE_BITS 8

// Bias setting widths
`define SWITCH_BITS 8
`define BIAS_BITS   6

// Extra high cycles per pin pulse, beyond the first
`define PULSE_HIGH_CYCLES 0

`endif

// ==== rtl/imager_pkg.sv ====
// Imager controller types
`include "imager_settings.svh"

package imager_pkg;

    //////////////////////////////////////////////////////////////////////
    // Chip register map
    //////////////////////////////////////////////////////////////////////

    // Order is fixed by the imager silicon
    typedef enum logic [`REG_PTR_BITS-1:0] {
        ptr_colsel = 3'd0,
        ptr_rowsel = 3'd1,
        ptr_vsw    = 3'd2,
        ptr_hsw    = 3'd3,
        ptr_vref   = 3'd4,
        ptr_config = 3'd5,
        ptr_nbias  = 3'd6,
        ptr_aobias = 3'd7
    } reg_ptr_e;

    //////////////////////////////////////////////////////////////////////
    // Control pin operations
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        op_reset_ptr,
        op_incr_ptr,
        op_reset_val,
        op_incr_val
    } pin_op_e;

    // Value held in one chip register
    typedef logic [`REG_VALUE_BITS-1:0] reg_value_t;

    // Row or column address
    typedef logic [`PIXEL_IDX_BITS-1:0] pixel_idx_t;

endpackage

// ==== rtl/chip_write_if.sv ====
// Chip register write channel
`timescale 1ns/100ps

interface chip_write_if import imager_pkg::*; ();

    // Request side, held steady until done
    logic       req;
    reg_ptr_e   ptr;
    reg_value_t value;

    // One-cycle pulse once the chip holds value at ptr
    logic       done;

    modport sequencer (
        output req,
        output ptr,
        output value,
        input  done
    );

    modport shadow (
        input  req,
        input  ptr,
        input  value,
        output done
    );

endinterface

// ==== rtl/pulse_generator.sv ====
// Chip control pin pulse generator
`timescale 1ns/100ps
`include "imager_settings.svh"

module pulse_generator import imager_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    pulse_req,
    input  pin_op_e pulse_op,
    output logic    pulse_done,
    output logic    resp,
    output logic    incp,
    output logic    resv,
    output logic    incv
);

    localparam int cnt_bits = $clog2(`PULSE_HIGH_CYCLES + 2);

    typedef enum logic {
        pg_idle,
        pg_high
    } pg_state_e;

    pg_state_e           state;
    pin_op_e             op_q;
    logic [cnt_bits-1:0] cnt;

    // Control state
    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= pg_idle;
            pulse_done <= 1'b0;
        end else begin
            pulse_done <= 1'b0;
            case (state)
                pg_idle: if (pulse_req) state <= pg_high;
                pg_high: begin
                    if (cnt == '0) begin
                        // Pin falls here, done follows in the low cycle
                        state      <= pg_idle;
                        pulse_done <= 1'b1;
                    end
                end
                default: state <= pg_idle;
            endcase
        end
    end

    // Latched operation and high-time counter
    always_ff @(posedge clk) begin
        if (state == pg_idle && pulse_req) begin
            op_q <= pulse_op;
            cnt  <= cnt_bits'(`PULSE_HIGH_CYCLES);
        end else if (state == pg_high && cnt != '0) begin
            cnt <= cnt - 1'b1;
        end
    end

    // Only the latched pin is high, and only while in pg_high
    assign resp = (state == pg_high) && (op_q == op_reset_ptr);
    assign incp = (state == pg_high) && (op_q == op_incr_ptr);
    assign resv = (state == pg_high) && (op_q == op_reset_val);
    assign incv = (state == pg_high) && (op_q == op_incr_val);

endmodule

// ==== rtl/chip_register_shadow.sv ====
// Chip register shadow
`timescale 1ns/100ps
`include "imager_settings.svh"

module chip_register_shadow import imager_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    chip_write_if.shadow wr,
    output logic    pulse_req,
    output pin_op_e pulse_op,
    input  logic    pulse_done
);

    localparam int reg_count = 2 ** `REG_PTR_BITS;

    //////////////////////////////////////////////////////////////////////
    // Shadow of the chip state
    //////////////////////////////////////////////////////////////////////

    reg_ptr_e   ptr_q;
    reg_value_t vals [reg_count];

    // Pulse in flight and the operation it performs
    logic    busy;
    pin_op_e op_q;
    logic    done_q;

    logic    ptr_match;
    logic    val_match;
    pin_op_e next_op;

    assign ptr_match = (ptr_q == wr.ptr);
    assign val_match = (vals[ptr_q] == wr.value);

    // Pointer first, then the value under it
    always_comb begin
        if (!ptr_match) begin
            if (ptr_q < wr.ptr) begin
                next_op = op_incr_ptr;
            end else begin
                next_op = op_reset_ptr;
            end
        end else begin
            if (vals[ptr_q] < wr.value) begin
                next_op = op_incr_val;
            end else begin
                next_op = op_reset_val;
            end
        end
    end

    // Issue a pin operation while the request is still unmet
    assign pulse_req = wr.req && !done_q && !busy && !(ptr_match && val_match);
    assign pulse_op  = next_op;
    assign wr.done   = done_q;

    //////////////////////////////////////////////////////////////////////
    // Shadow update
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            // Chip powers up with pointer and registers cleared
            busy   <= 1'b0;
            done_q <= 1'b0;
            ptr_q  <= ptr_colsel;
            for (int i = 0; i < reg_count; i++) begin
                vals[i] <= '0;
            end
        end else begin
            done_q <= wr.req && !done_q && !busy && ptr_match && val_match;
            if (pulse_req) begin
                busy <= 1'b1;
            end else if (pulse_done) begin
                busy <= 1'b0;
                case (op_q)
                    op_reset_ptr: ptr_q <= ptr_colsel;
                    op_incr_ptr:  ptr_q <= reg_ptr_e'(ptr_q + 3'd1);
                    op_reset_val: vals[ptr_q] <= '0;
                    op_incr_val:  vals[ptr_q] <= vals[ptr_q] + 1'b1;
                    default:      ptr_q <= ptr_q;
                endcase
            end
        end
    end

    // Remembered until the pulse completes
    always_ff @(posedge clk) begin
        if (pulse_req) begin
            op_q <= next_op;
        end
    end

endmodule

// ==== rtl/imager_sequencer.sv ====
// Imager frame sequencer
`timescale 1ns/100ps
`include "imager_settings.svh"

module imager_sequencer import imager_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    frame_capture_start,
    input  logic                    adc_capture_done,
    input  logic                    mask_capture_pixel,
    input  logic [`SWITCH_BITS-1:0] vsw_value,
    input  logic [`SWITCH_BITS-1:0] hsw_value,
    input  logic [`BIAS_BITS-1:0]   vref_value,
    input  logic [`BIAS_BITS-1:0]   config_value,
    input  logic [`BIAS_BITS-1:0]   nbias_value,
    input  logic [`BIAS_BITS-1:0]   aobias_value,
    chip_write_if.sequencer         wr,
    output logic                    ready,
    output logic                    frame_capture_done,
    output logic                    adc_capture_start,
    output pixel_idx_t              mask_pixel_row,
    output pixel_idx_t              mask_pixel_col
);

    localparam pixel_idx_t last_row = pixel_idx_t'(`ROW_RESOLUTION - 1);
    localparam pixel_idx_t last_col = pixel_idx_t'(`COL_RESOLUTION - 1);

    typedef enum logic [2:0] {
        st_init,
        st_idle,
        st_row,
        st_col,
        st_adc
    } seq_state_e;

    seq_state_e state;

    // Position in the initialisation write list
    logic [2:0] init_idx;

    // Move on to the next pixel this cycle
    logic pixel_step;

    assign ready = (state == st_idle);

    assign pixel_step = (state == st_col && wr.done && !mask_capture_pixel) ||
                        (state == st_adc && adc_capture_done);

    //////////////////////////////////////////////////////////////////////
    // Write request
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        wr.req   = 1'b0;
        wr.ptr   = ptr_colsel;
        wr.value = '0;
        case (state)
            st_init: begin
                wr.req = 1'b1;
                case (init_idx)
                    3'd0: wr.ptr = ptr_colsel;
                    3'd1: wr.ptr = ptr_rowsel;
                    3'd2: begin
                        wr.ptr   = ptr_vsw;
                        wr.value = reg_value_t'(vsw_value);
                    end
                    3'd3: begin
                        wr.ptr   = ptr_hsw;
                        wr.value = reg_value_t'(hsw_value);
                    end
                    3'd4: begin
                        wr.ptr   = ptr_vref;
                        wr.value = reg_value_t'(vref_value);
                    end
                    3'd5: begin
                        wr.ptr   = ptr_nbias;
                        wr.value = reg_value_t'(nbias_value);
                    end
                    3'd6: begin
                        wr.ptr   = ptr_aobias;
                        wr.value = reg_value_t'(aobias_value);
                    end
                    default: begin
                        wr.ptr   = ptr_config;
                        wr.value = reg_value_t'(config_value);
                    end
                endcase
            end
            st_row: begin
                wr.req   = 1'b1;
                wr.ptr   = ptr_rowsel;
                wr.value = reg_value_t'(mask_pixel_row);
            end
            st_col: begin
                wr.req   = 1'b1;
                wr.ptr   = ptr_colsel;
                wr.value = reg_value_t'(mask_pixel_col);
            end
            default: begin
                wr.req = 1'b0;
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Main state machine
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state              <= st_init;
            init_idx           <= 3'd0;
            mask_pixel_row     <= '0;
            mask_pixel_col     <= '0;
            adc_capture_start  <= 1'b0;
            frame_capture_done <= 1'b0;
        end else begin
            adc_capture_start  <= 1'b0;
            frame_capture_done <= 1'b0;
            case (state)
                st_init: begin
                    if (wr.done) begin
                        if (init_idx == 3'd7) begin
                            state <= st_idle;
                        end else begin
                            init_idx <= init_idx + 3'd1;
                        end
                    end
                end
                // Start requests outside idle are dropped
                st_idle: if (frame_capture_start) state <= st_row;
                st_row:  if (wr.done) state <= st_col;
                st_col: begin
                    // Both selects now hold the pixel
                    if (wr.done && mask_capture_pixel) begin
                        adc_capture_start <= 1'b1;
                        state             <= st_adc;
                    end
                end
                default: state <= state;
            endcase

            // Raster advance, wrapping to the next row
            if (pixel_step) begin
                if (mask_pixel_col != last_col) begin
                    mask_pixel_col <= mask_pixel_col + 1'b1;
                    state          <= st_row;
                end else if (mask_pixel_row != last_row) begin
                    mask_pixel_col <= '0;
                    mask_pixel_row <= mask_pixel_row + 1'b1;
                    state          <= st_row;
                end else begin
                    mask_pixel_col     <= '0;
                    mask_pixel_row     <= '0;
                    frame_capture_done <= 1'b1;
                    state              <= st_idle;
                end
            end
        end
    end

endmodule

// ==== rtl/stonyman_top.sv ====
// Stonyman imager controller top
`timescale 1ns/100ps
`include "imager_settings.svh"

module stonyman_top import imager_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    frame_capture_start,
    input  logic                    adc_capture_done,
    input  logic                    mask_capture_pixel,
    input  logic [`SWITCH_BITS-1:0] vsw_value,
    input  logic [`SWITCH_BITS-1:0] hsw_value,
    input  logic [`BIAS_BITS-1:0]   vref_value,
    input  logic [`BIAS_BITS-1:0]   config_value,
    input  logic [`BIAS_BITS-1:0]   nbias_value,
    input  logic [`BIAS_BITS-1:0]   aobias_value,
    output logic                    ready,
    output logic                    frame_capture_done,
    output logic                    adc_capture_start,
    output pixel_idx_t              mask_pixel_row,
    output pixel_idx_t              mask_pixel_col,
    output logic                    resp,
    output logic                    incp,
    output logic                    resv,
    output logic                    incv
);

    // Shadow to pulse generator
    logic    pulse_req;
    pin_op_e pulse_op;
    logic    pulse_done;

    chip_write_if wr_if ();

    imager_sequencer imager_sequencer_i (
        .clk                 (clk),
        .reset               (reset),
        .frame_capture_start (frame_capture_start),
        .adc_capture_done    (adc_capture_done),
        .mask_capture_pixel  (mask_capture_pixel),
        .vsw_value           (vsw_value),
        .hsw_value           (hsw_value),
        .vref_value          (vref_value),
        .config_value        (config_value),
        .nbias_value         (nbias_value),
        .aobias_value        (aobias_value),
        .wr                  (wr_if.sequencer),
        .ready               (ready),
        .frame_capture_done  (frame_capture_done),
        .adc_capture_start   (adc_capture_start),
        .mask_pixel_row      (mask_pixel_row),
        .mask_pixel_col      (mask_pixel_col)
    );

    chip_register_shadow chip_register_shadow_i (
        .clk        (clk),
        .reset      (reset),
        .wr         (wr_if.shadow),
        .pulse_req  (pulse_req),
        .pulse_op   (pulse_op),
        .pulse_done (pulse_done)
    );

    pulse_generator pulse_generator_i (
        .clk        (clk),
        .reset      (reset),
        .pulse_req  (pulse_req),
        .pulse_op   (pulse_op),
        .pulse_done (pulse_done),
        .resp       (resp),
        .incp       (incp),
        .resv       (resv),
        .incv       (incv)
    );

endmodule

// ==== tb/stonyman_assert.sv ====
// Controller protocol assertions
`timescale 1ns/100ps

module stonyman_assert (
    input logic clk,
    input logic reset,
    input logic resp,
    input logic incp,
    input logic resv,
    input logic incv,
    input logic adc_capture_start,
    input logic adc_capture_done,
    input logic frame_capture_done
);

    // Count of failed assertions
    int   failures = 0;
    logic adc_wait;

    // High from an ADC start until its done
    always_ff @(posedge clk) begin
        if (reset) begin
            adc_wait <= 1'b0;
        end else if (adc_capture_start) begin
            adc_wait <= 1'b1;
        end else if (adc_capture_done) begin
            adc_wait <= 1'b0;
        end
    end

    assert property (@(posedge clk) disable iff (reset) $onehot0({resp, incp, resv, incv}))
        else begin
            failures++;
            $error("more than one control pin high");
        end

    assert property (@(posedge clk) disable iff (reset) adc_capture_start |=> !adc_capture_start)
        else begin
            failures++;
            $error("adc_capture_start longer than one cycle");
        end

    assert property (@(posedge clk) disable iff (reset)
        frame_capture_done |=> !frame_capture_done)
        else begin
            failures++;
            $error("frame_capture_done longer than one cycle");
        end

    assert property (@(posedge clk) disable iff (reset)
        adc_wait |-> !(resp || incp || resv || incv))
        else begin
            failures++;
            $error("control pin pulsed while waiting for the ADC");
        end

endmodule

bind stonyman_top stonyman_assert stonyman_assert_i (.*);

// ==== tb/stonyman_tb.sv ====
// Imager controller testbench
`timescale 1ns/100ps
`include "imager_settings.svh"

module stonyman_tb import imager_pkg::*; ();

    localparam int pixel_count = `ROW_RESOLUTION * `COL_RESOLUTION;
    // Three frames at a generous per-pixel cycle budget, plus initialisation
    localparam longint watchdog_ns = 64'd3 * pixel_count * 40 * 4 + 64'd200000;

    logic clk = 1'b0;
    logic reset;
    logic frame_capture_start;
    logic adc_capture_done;
    logic mask_capture_pixel;
    logic [`SWITCH_BITS-1:0] vsw_value, hsw_value;
    logic [`BIAS_BITS-1:0] vref_value, config_value, nbias_value, aobias_value;
    logic ready, frame_capture_done, adc_capture_start;
    pixel_idx_t mask_pixel_row, mask_pixel_col;
    logic resp, incp, resv, incv;

    // Behavioural chip state
    logic [2:0] chip_ptr;
    logic [7:0] chip_regs [8];
    logic [3:0] pins_q;

    logic [31:0] rng_state;
    logic [31:0] mask_seed;
    int   check_count, error_count, capture_count, last_index, frame_no, total_errors;
    logic adc_busy, init_checked;

    stonyman_top stonyman_top_i (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Seed zero masks every pixel out
    function automatic logic expected_mask(input logic [31:0] seed, input int row, input int col);
        logic [31:0] h;
        h = xorshift(xorshift(seed ^ (row << 16) ^ col));
        return (seed != 0) && h[9];
    endfunction

    function automatic int expected_capture_count(input logic [31:0] seed);
        int n;
        n = 0;
        for (int r = 0; r < `ROW_RESOLUTION; r++) begin
            for (int c = 0; c < `COL_RESOLUTION; c++) begin
                n += expected_mask(seed, r, c);
            end
        end
        return n;
    endfunction

    // Combinational host answer
    assign mask_capture_pixel = expected_mask(mask_seed, mask_pixel_row, mask_pixel_col);

    task automatic check_that(input logic ok, input string what);
        check_count++;
        assert (ok) else begin
            error_count++;
            $display("ERROR %0t: %s", $time, what);
        end
    endtask

    // True if any pixel in [first, last) is masked in
    function automatic logic any_masked_in(input int first, input int last);
        logic found;
        found = 1'b0;
        for (int i = first; i < last; i++) begin
            found |= expected_mask(mask_seed, i / `COL_RESOLUTION, i % `COL_RESOLUTION);
        end
        return found;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Chip model counting one step per rising pin
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        pins_q <= {resp, incp, resv, incv};
        if (reset) begin
            chip_ptr <= '0;
            for (int i = 0; i < 8; i++) begin
                chip_regs[i] <= '0;
            end
        end else begin
            if (resp && !pins_q[3]) chip_ptr <= '0;
            if (incp && !pins_q[2]) chip_ptr <= chip_ptr + 1'b1;
            if (resv && !pins_q[1]) chip_regs[chip_ptr] <= '0;
            if (incv && !pins_q[0]) chip_regs[chip_ptr] <= chip_regs[chip_ptr] + 1'b1;
        end
    end

    // ADC with a random conversion time of 0 to 7 cycles
    always @(posedge clk) begin
        if (adc_capture_start) begin
            rng_state = xorshift(rng_state);
            repeat (rng_state[2:0]) @(posedge clk);
            #0.5 adc_capture_done = 1'b1;
            @(posedge clk);
            #0.5 adc_capture_done = 1'b0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Comparison
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        int cur;
        if (!reset) begin
            if (ready && !init_checked) begin
                init_checked = 1'b1;
                check_that(chip_regs[0] == 0 && chip_regs[1] == 0 &&
                           chip_regs[2] == vsw_value && chip_regs[3] == hsw_value &&
                           chip_regs[4] == vref_value && chip_regs[5] == config_value &&
                           chip_regs[6] == nbias_value && chip_regs[7] == aobias_value,
                           "chip registers after initialisation differ from the settings");
                $display("test init: errors %0d", error_count);
            end
            if (adc_busy) begin
                check_that({resp, incp, resv, incv} == 0 && !adc_capture_start,
                           "pin pulse or new ADC start while the ADC is busy");
                if (adc_capture_done) adc_busy = 1'b0;
            end
            if (adc_capture_start) begin
                adc_busy = 1'b1;
                cur = mask_pixel_row * `COL_RESOLUTION + mask_pixel_col;
                check_that(!ready, "ready high while a frame is being captured");
                check_that(chip_regs[1] == mask_pixel_row && chip_regs[0] == mask_pixel_col,
                           "select registers do not hold the captured pixel");
                check_that(expected_mask(mask_seed, mask_pixel_row, mask_pixel_col),
                           "capture of a masked-out pixel");
                check_that(cur > last_index, "capture out of raster order");
                check_that(!any_masked_in(last_index + 1, cur), "masked-in pixel skipped");
                last_index = cur;
                capture_count++;
            end
            if (frame_capture_done) begin
                frame_no++;
                check_that(!any_masked_in(last_index + 1, pixel_count),
                           "masked-in pixel after the last capture skipped");
                check_that(capture_count == expected_capture_count(mask_seed),
                           "wrong number of ADC starts in the frame");
                check_that(ready, "ready low with frame done");
                $display("test frame %0d: %0d captures, errors %0d",
                         frame_no, capture_count, error_count);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        reset = 1'b1;
        frame_capture_start = 1'b0;
        adc_capture_done = 1'b0;
        mask_seed = '0;
        rng_state = 32'd67348;
        check_count = 0;
        error_count = 0;
        capture_count = 0;
        frame_no = 0;
        last_index = -1;
        adc_busy = 1'b0;
        init_checked = 1'b0;
        rng_state = xorshift(rng_state);
        {vsw_value, hsw_value} = rng_state[15:0];
        {vref_value, config_value} = rng_state[27:16];
        rng_state = xorshift(rng_state);
        {nbias_value, aobias_value} = rng_state[11:0];
        repeat (3) @(posedge clk);
        #0.5 reset = 1'b0;
        do @(posedge clk); while (!ready);
        #0.5;
        for (int f = 0; f < 3; f++) begin
            // Third frame has every pixel masked out
            rng_state = xorshift(rng_state);
            mask_seed = (f == 2) ? 32'd0 : rng_state;
            capture_count = 0;
            last_index = -1;
            frame_capture_start = 1'b1;
            @(posedge clk);
            #0.5 frame_capture_start = 1'b0;
            if (f == 0) begin
                // Start pulse in the middle of a frame
                repeat (20) @(posedge clk);
                #0.5 frame_capture_start = 1'b1;
                @(posedge clk);
                #0.5 frame_capture_start = 1'b0;
            end
            do @(posedge clk); while (!frame_capture_done);
            #0.5;
            if (f == 0) begin
                repeat (8) begin
                    @(posedge clk);
                    check_that(ready, "controller left idle without a start");
                end
                $display("test ignored start: errors %0d", error_count);
                #0.5;
            end
        end
        total_errors = error_count + stonyman_top_i.stonyman_assert_i.failures;
        $display("checks %0d, errors %0d, assertion failures %0d",
                 check_count, error_count, stonyman_top_i.stonyman_assert_i.failures);
        if (total_errors == 0 && init_checked) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(watchdog_ns);
        $display("Timeout: the run did not finish within %0d ns", watchdog_ns);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+rtl
rtl/imager_pkg.sv
rtl/chip_write_if.sv
rtl/pulse_generator.sv
rtl/chip_register_shadow.sv
rtl/imager_sequencer.sv
rtl/stonyman_top.sv
tb/stonyman_assert.sv
tb/stonyman_tb.sv
